/* src/usbRxPkg.sv */
package usbRxPkg;

    // ==========================================================
    // Widths with a meaning
    // ==========================================================
    typedef logic [7:0] rxByteT;
    typedef logic [3:0] pidT;
    typedef logic [4:0] crc5T;
    typedef logic [15:0] crc16T;

    // Last four sync bits (0,0,0,1) once they reach the top of the shift register
    localparam logic [3:0] syncValue = 4'b1000;

    // Data packet PIDs, low nibble as sent
    localparam pidT pidData0 = 4'b0011;
    localparam pidT pidData1 = 4'b1011;

    // Remainders left in the registers after a good packet
    localparam crc5T crc5Residue = 5'b01100;
    localparam crc16T crc16Residue = 16'h800D;

    // ==========================================================
    // Bundles
    // ==========================================================
    // One byte on its way to the backend
    typedef struct packed {
        rxByteT data;
        logic isLast;
        logic packetOk;
    } rxEntryT;

    // Result of one bit time on the line
    typedef struct packed {
        logic bitValid;
        logic lineBit;
        logic stuffError;
        logic lineError;
        logic eop;
    } lineStatusT;

    typedef enum logic [1:0] {
        waitSync,
        getPid,
        getData,
        finishPacket
    } rxStateT;

endpackage

/* src/nrziUnstuff.sv */
`timescale 1ns/1ps

module nrziUnstuff
    import usbRxPkg::*;
(
    input  logic       clk48,
    input  logic       rxRST,
    input  logic       bitStrobe,
    input  logic       dataInP,
    input  logic       dataInN,
    input  logic       restart,
    output lineStatusT status
);

    logic prevLevel;
    logic [2:0] onesRun;
    logic [1:0] se0Run;
    logic se0;
    logic se1;
    logic isJ;
    logic rawBit;

    // Line states, J is P high at full speed
    assign se0 = !dataInP && !dataInN;
    assign se1 = dataInP && dataInN;
    assign isJ = dataInP && !dataInN;

    // NRZI: no transition means a one
    assign rawBit = (dataInP == prevLevel);

    always_ff @(posedge clk48) begin
        if (rxRST || restart) begin
            // Bus idles in J between packets
            prevLevel <= 1'b1;
            onesRun <= '0;
            se0Run <= '0;
            status <= '0;
        end else begin
            // Flags last one cycle per bit time
            status.bitValid <= 1'b0;
            status.stuffError <= 1'b0;
            status.lineError <= 1'b0;
            status.eop <= 1'b0;
            if (bitStrobe) begin
                if (se0) begin
                    se0Run <= (se0Run == 2'd3) ? se0Run : se0Run + 1'b1;
                    onesRun <= '0;
                end else begin
                    se0Run <= '0;
                    prevLevel <= dataInP;
                    status.lineError <= se1;
                    if (se0Run >= 2'd2 && isJ) begin
                        // Two SE0 bit times then J
                        status.eop <= 1'b1;
                    end else if (onesRun == 3'd6) begin
                        // Stuffed bit is dropped, it must have been a zero
                        onesRun <= '0;
                        status.stuffError <= rawBit;
                    end else begin
                        status.bitValid <= 1'b1;
                        status.lineBit <= rawBit;
                        onesRun <= rawBit ? onesRun + 1'b1 : 3'd0;
                    end
                end
            end
        end
    end

endmodule

/* src/rxDeserializer.sv */
`timescale 1ns/1ps

module rxDeserializer
    import usbRxPkg::*;
(
    input  logic       clk48,
    input  logic       rxRST,
    input  lineStatusT status,
    input  logic       align,
    output rxByteT     byteData,
    output logic       byteStrobe,
    output logic       syncSeen
);

    rxByteT shiftReg;
    logic [2:0] bitCount;

    // Byte is complete in the shift register when byteStrobe rises
    assign byteData = shiftReg;

    // Sync hunt only while the decoder waits for a packet
    assign syncSeen = !align && (shiftReg[7:4] == syncValue);

    always_ff @(posedge clk48) begin
        if (rxRST) begin
            shiftReg <= '1;
            bitCount <= '0;
            byteStrobe <= 1'b0;
        end else begin
            byteStrobe <= 1'b0;
            // LSB first, newest bit enters at the top
            // EOP flushes the register so old bits cannot look like sync
            if (status.eop) begin
                shiftReg <= '1;
            end else if (status.bitValid) begin
                shiftReg <= {status.lineBit, shiftReg[7:1]};
            end
            if (!align) begin
                bitCount <= '0;
            end else if (status.bitValid) begin
                bitCount <= bitCount + 1'b1;
                byteStrobe <= (bitCount == 3'd7);
            end
        end
    end

endmodule

/* src/rxCrcCheck.sv */
`timescale 1ns/1ps

module rxCrcCheck
    import usbRxPkg::*;
(
    input  logic       clk48,
    input  logic       rxRST,
    input  lineStatusT status,
    input  logic       crcClear,
    input  logic       crcUse16,
    output logic       crcMatch
);

    crc5T crc5;
    crc16T crc16;
    logic fb5;
    logic fb16;

    // Feedback of the serial LFSRs
    assign fb5 = crc5[4] ^ status.lineBit;
    assign fb16 = crc16[15] ^ status.lineBit;

    // ==========================================================
    // Both registers run, selection happens at the compare
    // ==========================================================
    always_ff @(posedge clk48) begin
        if (rxRST || crcClear) begin
            // Preset to all ones before the first bit after the PID
            crc5 <= '1;
            crc16 <= '1;
        end else if (status.bitValid) begin
            // x^5 + x^2 + 1
            crc5 <= {crc5[3:0], 1'b0} ^ (fb5 ? 5'h05 : 5'h00);
            // x^16 + x^15 + x^2 + 1
            crc16 <= {crc16[14:0], 1'b0} ^ (fb16 ? 16'h8005 : 16'h0000);
        end
    end

    // Level, read by the decoder at EOP
    assign crcMatch = crcUse16 ? (crc16 == crc16Residue) : (crc5 == crc5Residue);

endmodule

/* src/rxPacketDecoder.sv */
`timescale 1ns/1ps

module rxPacketDecoder
    import usbRxPkg::*;
#(
    parameter int holdBytes = 2
) (
    input  logic       clk48,
    input  logic       rxRST,
    input  lineStatusT status,
    input  rxByteT     byteData,
    input  logic       byteStrobe,
    input  logic       syncSeen,
    input  logic       crcMatch,
    output logic       align,
    output logic       restart,
    output logic       crcClear,
    output logic       crcUse16,
    output logic       wrEn,
    output rxEntryT    wrEntry,
    output logic       packetAbort
);

    // Delay line holds the CRC16 bytes plus the byte that may become last
    localparam int depth = holdBytes + 1;
    localparam int cntW = $clog2(depth + 1);

    rxStateT state;
    rxByteT holdData [depth];
    logic [cntW-1:0] holdCnt;
    logic [cntW-1:0] keepCnt;
    logic isData;
    logic dropPacket;
    logic hasPayload;
    logic fullWindow;
    logic pidOk;
    logic pidIsData;
    logic lineFault;
    logic crcOk;
    pidT pidLow;
    rxByteT oldest;
    rxByteT lastData;

    // ==========================================================
    // Control to the neighbours
    // ==========================================================
    assign align = (state != waitSync);
    assign restart = (state == finishPacket);
    assign crcClear = (state == waitSync) || (state == getPid);
    assign crcUse16 = isData;

    // PID check, upper nibble is the complement of the lower
    assign pidLow = byteData[3:0];
    assign pidOk = (byteData[7:4] == ~pidLow);
    assign pidIsData = (pidLow == pidData0) || (pidLow == pidData1);

    assign lineFault = status.stuffError || status.lineError;
    // Handshakes carry no CRC
    assign crcOk = !hasPayload || crcMatch;

    // Data packets keep depth bytes back, others just one
    assign keepCnt = isData ? cntW'(depth) : cntW'(1);
    assign fullWindow = (holdCnt == keepCnt);
    assign oldest = holdData[keepCnt - 1'b1];
    assign lastData = fullWindow ? oldest : holdData[0];

    // Byte delay line, newest at index 0
    always_ff @(posedge clk48) begin
        if (byteStrobe && (state == getPid || state == getData)) begin
            holdData[0] <= byteData;
            for (int i = 1; i < depth; i++) begin
                holdData[i] <= holdData[i-1];
            end
        end
    end

    // ==========================================================
    // Receive FSM
    // ==========================================================
    always_ff @(posedge clk48) begin
        if (rxRST) begin
            state <= waitSync;
            holdCnt <= '0;
            isData <= 1'b0;
            dropPacket <= 1'b0;
            hasPayload <= 1'b0;
            wrEn <= 1'b0;
            packetAbort <= 1'b0;
        end else begin
            wrEn <= 1'b0;
            packetAbort <= 1'b0;
            unique case (state)
                waitSync: begin
                    if (syncSeen) begin
                        state <= getPid;
                        holdCnt <= '0;
                        dropPacket <= 1'b0;
                        hasPayload <= 1'b0;
                    end
                end
                getPid: begin
                    if (lineFault) begin
                        dropPacket <= 1'b1;
                    end
                    if (status.eop) begin
                        // Packet ended before its PID, nothing to deliver
                        packetAbort <= 1'b1;
                        state <= finishPacket;
                    end else if (byteStrobe) begin
                        isData <= pidIsData;
                        holdCnt <= cntW'(1);
                        if (!pidOk) begin
                            dropPacket <= 1'b1;
                        end
                        state <= getData;
                    end
                end
                getData: begin
                    if (lineFault) begin
                        dropPacket <= 1'b1;
                    end
                    if (status.eop) begin
                        // Held CRC bytes are discarded here
                        wrEn <= 1'b1;
                        wrEntry.data <= lastData;
                        wrEntry.isLast <= 1'b1;
                        wrEntry.packetOk <= !dropPacket && !lineFault && crcOk && fullWindow;
                        state <= finishPacket;
                    end else if (byteStrobe) begin
                        hasPayload <= 1'b1;
                        if (fullWindow) begin
                            wrEn <= 1'b1;
                            wrEntry <= '{data: oldest, isLast: 1'b0, packetOk: 1'b1};
                        end else begin
                            holdCnt <= holdCnt + 1'b1;
                        end
                    end
                end
                finishPacket: begin
                    state <= waitSync;
                end
                default: begin
                    state <= waitSync;
                end
            endcase
        end
    end

endmodule

/* src/rxByteQueue.sv */
`timescale 1ns/1ps

module rxByteQueue
    import usbRxPkg::*;
#(
    parameter int queueDepth = 4
) (
    input  logic    clk48,
    input  logic    rxRST,
    input  logic    wrEn,
    input  rxEntryT wrEntry,
    input  logic    rdEn,
    output rxEntryT rdEntry,
    output logic    empty
);

    localparam int ptrW = $clog2(queueDepth);
    localparam int cntW = $clog2(queueDepth + 1);

    rxEntryT mem [queueDepth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [ptrW-1:0] prevPtr;
    logic [cntW-1:0] count;
    logic full;
    logic doWrite;
    logic doRead;
    logic patchLast;
    logic lossPending;

    // Circular increment for any depth
    function automatic logic [ptrW-1:0] bump(input logic [ptrW-1:0] ptr);
        return (ptr == ptrW'(queueDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full = (count == cntW'(queueDepth));
    assign doWrite = wrEn && !full;
    assign doRead = rdEn && !empty;
    assign rdEntry = mem[rdPtr];

    // Newest stored entry
    assign prevPtr = (wrPtr == '0) ? ptrW'(queueDepth - 1) : wrPtr - 1'b1;
    // Last byte lost to overflow, close the packet on the newest entry instead
    assign patchLast = wrEn && full && wrEntry.isLast && !mem[prevPtr].isLast;

    // ==========================================================
    // Storage
    // ==========================================================
    always_ff @(posedge clk48) begin
        if (doWrite) begin
            mem[wrPtr].data <= wrEntry.data;
            mem[wrPtr].isLast <= wrEntry.isLast;
            // A lost byte earlier in the packet spoils its verdict
            mem[wrPtr].packetOk <= wrEntry.packetOk && !(wrEntry.isLast && lossPending);
        end else if (patchLast) begin
            mem[prevPtr].isLast <= 1'b1;
            mem[prevPtr].packetOk <= 1'b0;
        end
    end

    // Pointers, fill level and loss tracking
    always_ff @(posedge clk48) begin
        if (rxRST) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            lossPending <= 1'b0;
        end else begin
            if (doWrite) begin
                wrPtr <= bump(wrPtr);
            end
            if (doRead) begin
                rdPtr <= bump(rdPtr);
            end
            if (doWrite && !doRead) begin
                count <= count + 1'b1;
            end else if (doRead && !doWrite) begin
                count <= count - 1'b1;
            end
            if (wrEn && full) begin
                lossPending <= !wrEntry.isLast;
            end else if (doWrite && wrEntry.isLast) begin
                lossPending <= 1'b0;
            end
        end
    end

endmodule

/* src/rxBytePort.sv */
`timescale 1ns/1ps

module rxBytePort
    import usbRxPkg::*;
#(
    parameter int missLimit = 64
) (
    input  logic    clk48,
    input  logic    rxRST,
    input  rxEntryT rdEntry,
    input  logic    empty,
    input  logic    rxAcceptNewData,
    output logic    rdEn,
    output rxByteT  rxData,
    output logic    rxDataValid,
    output logic    rxIsLastByte,
    output logic    keepPacket
);

    localparam int waitW = $clog2(missLimit + 1);

    logic [waitW-1:0] waitCnt;
    logic taken;
    logic waiting;
    logic missNow;
    logic missed;
    logic missedNext;

    // Backend handshake
    assign taken = rxDataValid && rxAcceptNewData;

    // Next byte of the same packet is queued behind an untaken one
    assign waiting = rxDataValid && !rxIsLastByte && !empty && !taken;
    assign missNow = waiting && (waitCnt == waitW'(missLimit));

    // Output register free, or being freed this cycle
    assign rdEn = !empty && (!rxDataValid || taken || missNow);

    // Miss flag lives until the packet's last byte leaves
    assign missedNext = missNow || (missed && !(taken && rxIsLastByte));

    always_ff @(posedge clk48) begin
        if (rdEn) begin
            rxData <= rdEntry.data;
        end
    end

    // ==========================================================
    // Handshake and verdict
    // ==========================================================
    always_ff @(posedge clk48) begin
        if (rxRST) begin
            rxDataValid <= 1'b0;
            rxIsLastByte <= 1'b0;
            keepPacket <= 1'b0;
            missed <= 1'b0;
            waitCnt <= '0;
        end else begin
            missed <= missedNext;
            waitCnt <= (waiting && !missNow) ? waitCnt + 1'b1 : '0;
            if (rdEn) begin
                rxDataValid <= 1'b1;
                rxIsLastByte <= rdEntry.isLast;
                keepPacket <= rdEntry.packetOk && !missedNext;
            end else if (taken) begin
                rxDataValid <= 1'b0;
                rxIsLastByte <= 1'b0;
            end
        end
    end

endmodule

/* src/usbRx.sv */
`timescale 1ns/1ps

module usbRx
    import usbRxPkg::*;
#(
    parameter int queueDepth = 4,
    parameter int missLimit = 64
) (
    input  logic   clk48,
    input  logic   rxRST,
    input  logic   bitStrobe,
    input  logic   dataInP,
    input  logic   dataInN,
    input  logic   rxAcceptNewData,
    output rxByteT rxData,
    output logic   rxDataValid,
    output logic   rxIsLastByte,
    output logic   keepPacket
);

    lineStatusT lineStatus;
    rxByteT byteData;
    rxEntryT wrEntry;
    rxEntryT rdEntry;
    logic byteStrobe;
    logic syncSeen;
    logic align;
    logic restart;
    logic crcClear;
    logic crcUse16;
    logic crcMatch;
    logic wrEn;
    logic rdEn;
    logic empty;

    // ==========================================================
    // Bit level
    // ==========================================================
    nrziUnstuff lineDecode (
        .clk48(clk48),
        .rxRST(rxRST),
        .bitStrobe(bitStrobe),
        .dataInP(dataInP),
        .dataInN(dataInN),
        .restart(restart),
        .status(lineStatus)
    );

    rxDeserializer byteAssembly (
        .clk48(clk48),
        .rxRST(rxRST),
        .status(lineStatus),
        .align(align),
        .byteData(byteData),
        .byteStrobe(byteStrobe),
        .syncSeen(syncSeen)
    );

    rxCrcCheck crcCheck (
        .clk48(clk48),
        .rxRST(rxRST),
        .status(lineStatus),
        .crcClear(crcClear),
        .crcUse16(crcUse16),
        .crcMatch(crcMatch)
    );

    // ==========================================================
    // Packet level and backend
    // ==========================================================
    // Abort pulse left open, probe point only
    rxPacketDecoder packetDecode (
        .clk48(clk48),
        .rxRST(rxRST),
        .status(lineStatus),
        .byteData(byteData),
        .byteStrobe(byteStrobe),
        .syncSeen(syncSeen),
        .crcMatch(crcMatch),
        .align(align),
        .restart(restart),
        .crcClear(crcClear),
        .crcUse16(crcUse16),
        .wrEn(wrEn),
        .wrEntry(wrEntry),
        .packetAbort()
    );

    rxByteQueue #(
        .queueDepth(queueDepth)
    ) byteQueue (
        .clk48(clk48),
        .rxRST(rxRST),
        .wrEn(wrEn),
        .wrEntry(wrEntry),
        .rdEn(rdEn),
        .rdEntry(rdEntry),
        .empty(empty)
    );

    rxBytePort #(
        .missLimit(missLimit)
    ) bytePort (
        .clk48(clk48),
        .rxRST(rxRST),
        .rdEntry(rdEntry),
        .empty(empty),
        .rxAcceptNewData(rxAcceptNewData),
        .rdEn(rdEn),
        .rxData(rxData),
        .rxDataValid(rxDataValid),
        .rxIsLastByte(rxIsLastByte),
        .keepPacket(keepPacket)
    );

endmodule

/* bench/usbRxTb.sv */
`timescale 1ns/1ps

module usbRxTb
    import usbRxPkg::*;
();

    localparam int queueDepth = 4;
    localparam int missLimit = 64;
    localparam int numCases = 11;
    localparam int collectTimeout = 4000;

    // Non-data PIDs, low nibble as sent
    localparam pidT pidOut = 4'b0001;
    localparam pidT pidIn = 4'b1001;
    localparam pidT pidAck = 4'b0010;

    // Line symbols as {P, N}
    localparam logic [1:0] symJ = 2'b10;
    localparam logic [1:0] symK = 2'b01;
    localparam logic [1:0] symSe0 = 2'b00;
    localparam logic [1:0] symSe1 = 2'b11;

    typedef enum logic [2:0] {
        errNone,
        errBadPid,
        errCrcFlip,
        errStuff,
        errSe1
    } errKindT;

    // One row of the stimulus table
    typedef struct packed {
        pidT pid;
        logic [7:0] payloadLen;
        errKindT err;
        logic [11:0] stallCycles;
        logic keepExp;
    } packetCaseT;

    logic clk48;
    logic rxRST;
    logic bitStrobe;
    logic dataInP;
    logic dataInN;
    logic rxAcceptNewData;
    rxByteT rxData;
    logic rxDataValid;
    logic rxIsLastByte;
    logic keepPacket;

    packetCaseT caseTable [numCases];
    logic pktBits [$];
    logic [1:0] lineSyms [$];
    rxByteT expBytes [$];
    logic nrziLevel;
    integer seed;

    usbRx #(
        .queueDepth(queueDepth),
        .missLimit(missLimit)
    ) dut0 (
        .clk48(clk48),
        .rxRST(rxRST),
        .bitStrobe(bitStrobe),
        .dataInP(dataInP),
        .dataInN(dataInN),
        .rxAcceptNewData(rxAcceptNewData),
        .rxData(rxData),
        .rxDataValid(rxDataValid),
        .rxIsLastByte(rxIsLastByte),
        .keepPacket(keepPacket)
    );

    // 4 ns period
    initial begin
        clk48 = 1'b0;
        forever #2 clk48 = ~clk48;
    end

    // ==========================================================
    // Failure handling and compare tasks
    // ==========================================================
    task automatic abortRun();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkByte(input string name, input rxByteT got, input rxByteT exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got 0x%02h expected 0x%02h", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
            abortRun();
        end
    endtask

    // ==========================================================
    // CRC model, reflected form with LSB first shifting
    // ==========================================================
    function automatic crc5T crc5Update(input crc5T r, input logic din);
        if (r[0] ^ din) begin
            return (r >> 1) ^ 5'h14;
        end
        return r >> 1;
    endfunction

    function automatic crc16T crc16Update(input crc16T r, input logic din);
        if (r[0] ^ din) begin
            return (r >> 1) ^ 16'hA001;
        end
        return r >> 1;
    endfunction

    // ==========================================================
    // Stimulus table
    // ==========================================================
    function automatic packetCaseT makeCase(input pidT pid, input int len, input errKindT err,
                                            input int stall, input logic keep);
        packetCaseT pc;
        pc.pid = pid;
        pc.payloadLen = 8'(len);
        pc.err = err;
        pc.stallCycles = 12'(stall);
        pc.keepExp = keep;
        return pc;
    endfunction

    task automatic loadCases();
        // Clean data, token and handshake packets
        caseTable[0] = makeCase(pidData0, 4, errNone, 0, 1'b1);
        caseTable[1] = makeCase(pidOut, 0, errNone, 0, 1'b1);
        caseTable[2] = makeCase(pidAck, 0, errNone, 0, 1'b1);
        // Each fault kind must drop the packet
        caseTable[3] = makeCase(pidData1, 3, errCrcFlip, 0, 1'b0);
        caseTable[4] = makeCase(pidData0, 2, errBadPid, 0, 1'b0);
        caseTable[5] = makeCase(pidData1, 3, errStuff, 0, 1'b0);
        caseTable[6] = makeCase(pidOut, 0, errSe1, 0, 1'b0);
        caseTable[7] = makeCase(pidIn, 0, errCrcFlip, 0, 1'b0);
        // Long stall loses bytes, following packet recovers
        caseTable[8] = makeCase(pidData0, 12, errNone, 400, 1'b0);
        caseTable[9] = makeCase(pidData1, 5, errNone, 0, 1'b1);
        // Zero length data packet, PID alone reaches the backend
        caseTable[10] = makeCase(pidData0, 0, errNone, 0, 1'b1);
    endtask

    // ==========================================================
    // Packet builder
    // ==========================================================
    task automatic pushByte(input rxByteT b);
        for (int i = 0; i < 8; i++) begin
            pktBits.push_back(b[i]);
        end
    endtask

    // NRZI, a zero toggles the line
    task automatic pushNrzi(input logic bitVal);
        if (!bitVal) begin
            nrziLevel = ~nrziLevel;
        end
        lineSyms.push_back(nrziLevel ? symJ : symK);
    endtask

    task automatic buildPacket(input packetCaseT pc);
        rxByteT b;
        crc5T r5;
        crc16T r16;
        logic [10:0] tokenField;
        logic isData;
        logic isToken;
        logic stuffPending;
        int nBytes;
        int ones;
        int k;
        pktBits.delete();
        lineSyms.delete();
        expBytes.delete();
        isData = (pc.pid == pidData0) || (pc.pid == pidData1);
        isToken = (pc.pid[1:0] == 2'b01);
        // Sync, seven zeros then a one
        for (int i = 0; i < 8; i++) begin
            pktBits.push_back(i == 7);
        end
        pushByte({~pc.pid, pc.pid});
        if (isData) begin
            for (int i = 0; i < pc.payloadLen; i++) begin
                b = rxByteT'($random(seed));
                // All ones forces a stuffed bit early in the payload
                if (i == 0 && pc.err == errStuff) begin
                    b = 8'hFF;
                end
                pushByte(b);
            end
            r16 = '1;
            for (int i = 16; i < pktBits.size(); i++) begin
                r16 = crc16Update(r16, pktBits[i]);
            end
            r16 = ~r16;
            for (int i = 0; i < 16; i++) begin
                pktBits.push_back(r16[i]);
            end
            nBytes = pc.payloadLen + 1;
        end else if (isToken) begin
            // Address and endpoint, 11 bits
            tokenField = 11'($random(seed));
            r5 = '1;
            for (int i = 0; i < 11; i++) begin
                pktBits.push_back(tokenField[i]);
                r5 = crc5Update(r5, tokenField[i]);
            end
            r5 = ~r5;
            for (int i = 0; i < 5; i++) begin
                pktBits.push_back(r5[i]);
            end
            nBytes = 3;
        end else begin
            nBytes = 1;
        end
        // Corruptions that change bits on the wire
        if (pc.err == errBadPid) begin
            pktBits[12] = ~pktBits[12];
        end else if (pc.err == errCrcFlip) begin
            pktBits[pktBits.size() - 1] = ~pktBits[pktBits.size() - 1];
        end
        // Expected bytes as they appear after sync, CRC16 bytes excluded
        for (k = 0; k < nBytes; k++) begin
            for (int i = 0; i < 8; i++) begin
                b[i] = pktBits[8 + 8 * k + i];
            end
            expBytes.push_back(b);
        end
        // Bit stuffing then NRZI, starting from idle J
        nrziLevel = 1'b1;
        ones = 0;
        stuffPending = (pc.err == errStuff);
        for (int i = 0; i < pktBits.size(); i++) begin
            pushNrzi(pktBits[i]);
            ones = pktBits[i] ? ones + 1 : 0;
            if (ones == 6) begin
                // A one here is a stuffing violation
                pushNrzi(stuffPending);
                stuffPending = 1'b0;
                ones = 0;
            end
        end
        // SE1 replaces a J, so P and the decoded bit stay the same
        if (pc.err == errSe1) begin
            k = 16;
            while (k < lineSyms.size() - 1 && lineSyms[k] != symJ) begin
                k++;
            end
            lineSyms[k] = symSe1;
        end
        // EOP then a short idle tail
        lineSyms.push_back(symSe0);
        lineSyms.push_back(symSe0);
        lineSyms.push_back(symJ);
        for (int i = 0; i < 4; i++) begin
            lineSyms.push_back(symJ);
        end
    endtask

    // ==========================================================
    // Line driver and backend model
    // ==========================================================
    // One bit time, strobe in the first of four cycles
    task automatic driveSymbol(input logic [1:0] sym, input logic quiet);
        for (int c = 0; c < 4; c++) begin
            @(negedge clk48);
            if (c == 0) begin
                dataInP = sym[1];
                dataInN = sym[0];
                bitStrobe = 1'b1;
            end else begin
                bitStrobe = 1'b0;
            end
            if (quiet) begin
                checkFlag("rxDataValid", rxDataValid, 1'b0);
            end
        end
    endtask

    task automatic sendLine();
        for (int i = 0; i < lineSyms.size(); i++) begin
            driveSymbol(lineSyms[i], 1'b0);
        end
    endtask

    task automatic collectPacket(input packetCaseT pc, input int idx);
        int cycles;
        int got;
        logic done;
        logic exact;
        cycles = 0;
        got = 0;
        done = 1'b0;
        // Stalled packets lose bytes, only the verdict is checked
        exact = (pc.stallCycles == 0);
        while (!done) begin
            @(negedge clk48);
            rxAcceptNewData = (cycles >= pc.stallCycles);
            // Both high here means the byte is taken at the next rising edge
            if (rxDataValid && rxAcceptNewData) begin
                if (got >= expBytes.size()) begin
                    $display("Packet %0d delivered more bytes than it holds at %0t ns",
                             idx, $time);
                    abortRun();
                end
                if (exact) begin
                    checkByte("rxData", rxData, expBytes[got]);
                    checkFlag("rxIsLastByte", rxIsLastByte, got == expBytes.size() - 1);
                end
                if (rxIsLastByte) begin
                    checkFlag("keepPacket", keepPacket, pc.keepExp);
                    done = 1'b1;
                end
                got++;
            end
            cycles++;
            if (!done && cycles >= collectTimeout) begin
                $display("Packet %0d saw no last byte within %0d cycles", idx, collectTimeout);
                abortRun();
            end
        end
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial begin
        seed = 78413;
        rxRST = 1'b1;
        bitStrobe = 1'b0;
        dataInP = 1'b1;
        dataInN = 1'b0;
        rxAcceptNewData = 1'b0;
        loadCases();
        repeat (8) @(posedge clk48);
        @(negedge clk48);
        rxRST = 1'b0;
        checkFlag("rxDataValid", rxDataValid, 1'b0);
        checkFlag("rxIsLastByte", rxIsLastByte, 1'b0);
        // Idle J after reset, no false sync
        for (int i = 0; i < 24; i++) begin
            driveSymbol(symJ, 1'b1);
        end
        for (int n = 0; n < numCases; n++) begin
            buildPacket(caseTable[n]);
            fork
                sendLine();
                collectPacket(caseTable[n], n);
            join
            rxAcceptNewData = 1'b0;
            // Gap between packets stays quiet
            for (int i = 0; i < 12; i++) begin
                driveSymbol(symJ, 1'b1);
            end
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* project.f */
src/usbRxPkg.sv
src/nrziUnstuff.sv
src/rxDeserializer.sv
src/rxCrcCheck.sv
src/rxPacketDecoder.sv
src/rxByteQueue.sv
src/rxBytePort.sv
src/usbRx.sv
bench/usbRxTb.sv
